// File: design/looper_pkg.sv
package looper_pkg;

	localparam int NUM_LANES = 4;
	localparam int DATA_W    = 16;
	localparam int PREG_W    = 6;
	localparam int NUM_PREGS = 64;
	localparam int ROB_IDX_W = 6;
	localparam int MODE_W    = 3;

	// alu mode codes
	localparam logic [MODE_W-1:0] MODE_ADD = 3'd0;
	localparam logic [MODE_W-1:0] MODE_SUB = 3'd1;
	localparam logic [MODE_W-1:0] MODE_AND = 3'd2;
	localparam logic [MODE_W-1:0] MODE_OR  = 3'd3;
	localparam logic [MODE_W-1:0] MODE_XOR = 3'd4;
	localparam logic [MODE_W-1:0] MODE_SHL = 3'd5;
	localparam logic [MODE_W-1:0] MODE_SHR = 3'd6;
	localparam logic [MODE_W-1:0] MODE_MUL = 3'd7;

	// issued instruction as it leaves the scheduler
	typedef struct packed {
		logic                 valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PREG_W-1:0]    src1;
		logic [PREG_W-1:0]    src2;
		logic [PREG_W-1:0]    dst;
		logic                 imm_vld;
		logic [DATA_W-1:0]    imm;
		logic                 ldi;
		logic [MODE_W-1:0]    mode;
		logic                 inv_rt;
		logic                 reg_wrt;
	} issue_pkt_t;

	// operands already resolved, ready for a lane
	typedef struct packed {
		logic                 valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PREG_W-1:0]    dst;
		logic                 reg_wrt;
		logic [MODE_W-1:0]    mode;
		logic                 inv_rt;
		logic                 ldi;
		logic [DATA_W-1:0]    op_a;
		logic [DATA_W-1:0]    op_b;
	} lane_op_t;

	// finished instruction, also the completion report
	typedef struct packed {
		logic                 valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PREG_W-1:0]    dst;
		logic                 reg_wrt;
		logic [DATA_W-1:0]    data;
	} lane_result_t;

endpackage

// File: design/phys_reg_file.sv
`timescale 1ns/1ns

module phys_reg_file (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [looper_pkg::PREG_W-1:0]    rd_addr [2*looper_pkg::NUM_LANES],
	output logic [looper_pkg::DATA_W-1:0]    rd_data [2*looper_pkg::NUM_LANES],
	input  logic [looper_pkg::NUM_LANES-1:0] wr_en,
	input  logic [looper_pkg::PREG_W-1:0]    wr_addr [looper_pkg::NUM_LANES],
	input  logic [looper_pkg::DATA_W-1:0]    wr_data [looper_pkg::NUM_LANES]
);

	import looper_pkg::*;

	logic [DATA_W-1:0] regs [NUM_PREGS];

	// all enabled ports land on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else begin
			for (int p = 0; p < NUM_LANES; p++) begin
				if (wr_en[p]) begin
					regs[wr_addr[p]] <= wr_data[p];
				end
			end
		end
	end

	// no bypass, a write is visible only after its edge
	always_comb begin
		for (int r = 0; r < 2*NUM_LANES; r++) begin
			rd_data[r] = regs[rd_addr[r]];
		end
	end

	// write-back must already have resolved same-dst conflicts
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_wr_a
		for (genvar j = i + 1; j < NUM_LANES; j++) begin : g_wr_b
			a_wr_unique: assert property (
				@(posedge clk) disable iff (!rst_n)
				!(wr_en[i] && wr_en[j] && (wr_addr[i] == wr_addr[j]))
			) else $error("write ports %0d and %0d both target p%0d", i, j, wr_addr[i]);
		end
	end

endmodule

// File: design/operand_fetch.sv
`timescale 1ns/1ns

module operand_fetch (
	input  logic                          clk,
	input  logic                          rst_n,
	input  looper_pkg::issue_pkt_t        issue   [looper_pkg::NUM_LANES],
	output logic [looper_pkg::PREG_W-1:0] rd_addr [2*looper_pkg::NUM_LANES],
	input  logic [looper_pkg::DATA_W-1:0] rd_data [2*looper_pkg::NUM_LANES],
	output looper_pkg::lane_op_t          lane_op [looper_pkg::NUM_LANES]
);

	import looper_pkg::*;

	logic       iss_vld [NUM_LANES];
	issue_pkt_t iss_q   [NUM_LANES];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				iss_vld[l] <= 1'b0;
			end
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				iss_vld[l] <= issue[l].valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		iss_q <= issue;
	end

	// two read ports per lane, src1 on the even one
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			rd_addr[2*l]   = iss_q[l].src1;
			rd_addr[2*l+1] = iss_q[l].src2;
		end
	end

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_op[l].valid   = iss_vld[l];
			lane_op[l].rob_idx = iss_q[l].rob_idx;
			lane_op[l].dst     = iss_q[l].dst;
			lane_op[l].reg_wrt = iss_q[l].reg_wrt;
			lane_op[l].mode    = iss_q[l].mode;
			lane_op[l].inv_rt  = iss_q[l].inv_rt;
			lane_op[l].ldi     = iss_q[l].ldi;
			lane_op[l].op_a    = rd_data[2*l];
			// immediate replaces src2
			lane_op[l].op_b    = iss_q[l].imm_vld ? iss_q[l].imm : rd_data[2*l+1];
		end
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
		a_pkt_known: assert property (
			@(posedge clk) disable iff (!rst_n)
			iss_vld[l] |-> !$isunknown(iss_q[l])
		) else $error("lane %0d issued packet has unknown bits", l);
	end

endmodule

// File: design/exec_lane.sv
`timescale 1ns/1ns

module exec_lane (
	input  logic                     clk,
	input  logic                     rst_n,
	input  looper_pkg::lane_op_t     op,
	output looper_pkg::lane_result_t result
);

	import looper_pkg::*;

	logic              op_vld;
	lane_op_t          op_q;
	logic [DATA_W-1:0] op_b_eff;
	logic [DATA_W-1:0] alu_out;
	logic              res_vld;
	lane_result_t      res_q;

	// read-to-execute register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_vld <= 1'b0;
		end else begin
			op_vld <= op.valid;
		end
	end

	always_ff @(posedge clk) begin
		op_q <= op;
	end

	assign op_b_eff = op_q.inv_rt ? ~op_q.op_b : op_q.op_b;

	always_comb begin
		if (op_q.ldi) begin
			alu_out = op_b_eff;
		end else begin
			case (op_q.mode)
				MODE_ADD: alu_out = op_q.op_a + op_b_eff;
				MODE_SUB: alu_out = op_q.op_a - op_b_eff;
				MODE_AND: alu_out = op_q.op_a & op_b_eff;
				MODE_OR:  alu_out = op_q.op_a | op_b_eff;
				MODE_XOR: alu_out = op_q.op_a ^ op_b_eff;
				MODE_SHL: alu_out = op_q.op_a << op_b_eff[3:0];
				MODE_SHR: alu_out = op_q.op_a >> op_b_eff[3:0];
				MODE_MUL: alu_out = op_q.op_a * op_b_eff;
				default:  alu_out = '0;
			endcase
		end
	end

	// execute-to-write-back register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_vld <= 1'b0;
		end else begin
			res_vld <= op_vld;
		end
	end

	always_ff @(posedge clk) begin
		res_q.valid   <= op_vld;
		res_q.rob_idx <= op_q.rob_idx;
		res_q.dst     <= op_q.dst;
		res_q.reg_wrt <= op_q.reg_wrt;
		res_q.data    <= alu_out;
	end

	always_comb begin
		result       = res_q;
		result.valid = res_vld;
	end

	// fixed latency from op port to result port
	a_res_follows_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		result.valid == $past(op.valid, 2)
	) else $error("lane result valid out of step with issued op");

endmodule

// File: design/writeback_collect.sv
`timescale 1ns/1ns

module writeback_collect (
	input  logic                             clk,
	input  logic                             rst_n,
	input  looper_pkg::lane_result_t         lane_result [looper_pkg::NUM_LANES],
	output logic [looper_pkg::NUM_LANES-1:0] wr_en,
	output logic [looper_pkg::PREG_W-1:0]    wr_addr     [looper_pkg::NUM_LANES],
	output logic [looper_pkg::DATA_W-1:0]    wr_data     [looper_pkg::NUM_LANES],
	output looper_pkg::lane_result_t         completion  [looper_pkg::NUM_LANES]
);

	import looper_pkg::*;

	logic                 cmp_vld [NUM_LANES];
	lane_result_t         cmp_q   [NUM_LANES];
	logic [NUM_LANES-1:0] wr_taken;

	// higher lane wins on a shared dst
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			wr_en[l]   = lane_result[l].valid && lane_result[l].reg_wrt;
			wr_addr[l] = lane_result[l].dst;
			wr_data[l] = lane_result[l].data;
			for (int h = l + 1; h < NUM_LANES; h++) begin
				if (lane_result[h].valid && lane_result[h].reg_wrt &&
				    (lane_result[h].dst == lane_result[l].dst)) begin
					wr_en[l] = 1'b0;
				end
			end
		end
	end

	// every valid result is reported even when not written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				cmp_vld[l] <= 1'b0;
			end
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				cmp_vld[l] <= lane_result[l].valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		cmp_q <= lane_result;
	end

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			completion[l]       = cmp_q[l];
			completion[l].valid = cmp_vld[l];
		end
	end

	// dst of each lane reaches the file through its own or a higher port
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			wr_taken[l] = wr_en[l];
			for (int h = l + 1; h < NUM_LANES; h++) begin
				if (wr_en[h] && (wr_addr[h] == lane_result[l].dst)) begin
					wr_taken[l] = 1'b1;
				end
			end
		end
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
		a_wr_not_lost: assert property (
			@(posedge clk) disable iff (!rst_n)
			(lane_result[l].valid && lane_result[l].reg_wrt) |-> wr_taken[l]
		) else $error("lane %0d write to p%0d is lost", l, lane_result[l].dst);
	end

endmodule

// File: design/looper_backend.sv
`timescale 1ns/1ns

module looper_backend (
	input  logic                     clk,
	input  logic                     rst_n,
	input  looper_pkg::issue_pkt_t   issue      [looper_pkg::NUM_LANES],
	output looper_pkg::lane_result_t completion [looper_pkg::NUM_LANES]
);

	import looper_pkg::*;

	logic [PREG_W-1:0]    rd_addr     [2*NUM_LANES];
	logic [DATA_W-1:0]    rd_data     [2*NUM_LANES];
	lane_op_t             lane_op     [NUM_LANES];
	lane_result_t         lane_result [NUM_LANES];
	logic [NUM_LANES-1:0] wr_en;
	logic [PREG_W-1:0]    wr_addr     [NUM_LANES];
	logic [DATA_W-1:0]    wr_data     [NUM_LANES];

	operand_fetch u_operand_fetch (
		.clk     (clk),
		.rst_n   (rst_n),
		.issue   (issue),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.lane_op (lane_op)
	);

	// four identical alu lanes
	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		exec_lane u_exec_lane (
			.clk    (clk),
			.rst_n  (rst_n),
			.op     (lane_op[l]),
			.result (lane_result[l])
		);
	end

	writeback_collect u_writeback_collect (
		.clk         (clk),
		.rst_n       (rst_n),
		.lane_result (lane_result),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.completion  (completion)
	);

	phys_reg_file u_phys_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

endmodule

// File: verif/looper_backend_tb.sv
`timescale 1ns/1ns

module looper_backend_tb;

	import looper_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 3;
	localparam int NUM_TESTS    = 6;
	localparam int IDLE_LEN     = 12;
	localparam int MODES_LEN    = 12;
	localparam int FLAGS_LEN    = 8;
	localparam int RANDOM_LEN   = 40;
	localparam int DEP_LEN      = 8;
	localparam int CONFLICT_LEN = 5;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_LEN + MODES_LEN + FLAGS_LEN + RANDOM_LEN +
		DEP_LEN + CONFLICT_LEN + DRAIN_CYCLES * NUM_TESTS + 50;

	logic              clk;
	logic              rst_n;
	issue_pkt_t        issue      [NUM_LANES];
	lane_result_t      completion [NUM_LANES];
	issue_pkt_t        nxt        [NUM_LANES];
	logic [31:0]       lfsr;
	logic [ROB_IDX_W-1:0] rob_ctr;
	int                cycles;

	// reference model state
	logic [DATA_W-1:0] shadow  [NUM_PREGS];
	lane_result_t      hist    [3][NUM_LANES];
	lane_result_t      exp_cmp [NUM_LANES];

	looper_backend DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.completion (completion)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [DATA_W-1:0] rand_bits(input int n);
		logic [DATA_W-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[DATA_W-2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic [DATA_W-1:0] calc_result(input logic [MODE_W-1:0] mode,
		input logic inv_rt, input logic ldi, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] rt;
		logic [31:0]       wide;
		rt = inv_rt ? ~b : b;
		if (ldi) begin
			return rt;
		end
		case (mode)
			MODE_ADD: wide = {16'h0, a} + {16'h0, rt};
			MODE_SUB: wide = {16'h0, a} - {16'h0, rt};
			MODE_AND: wide = {16'h0, a & rt};
			MODE_OR:  wide = {16'h0, a | rt};
			MODE_XOR: wide = {16'h0, a ^ rt};
			MODE_SHL: wide = {16'h0, a} << rt[3:0];
			MODE_SHR: wide = {16'h0, a} >> rt[3:0];
			default:  wide = {16'h0, a} * {16'h0, rt};
		endcase
		return wide[DATA_W-1:0];
	endfunction

	function automatic issue_pkt_t build_pkt(input logic [PREG_W-1:0] src1, src2, dst,
		input logic imm_vld, input logic [DATA_W-1:0] imm, input logic ldi,
		input logic [MODE_W-1:0] mode, input logic inv_rt, reg_wrt);
		issue_pkt_t p;
		p.valid   = 1'b1;
		p.rob_idx = '0;
		p.src1    = src1;
		p.src2    = src2;
		p.dst     = dst;
		p.imm_vld = imm_vld;
		p.imm     = imm;
		p.ldi     = ldi;
		p.mode    = mode;
		p.inv_rt  = inv_rt;
		p.reg_wrt = reg_wrt;
		return p;
	endfunction

	task automatic report_value(input string field, input int lane,
		input logic [DATA_W-1:0] exp_val, input logic [DATA_W-1:0] act_val);
		$display("error: completion[%0d].%s expected %h actual %h", lane, field, exp_val, act_val);
		$display("ERRORS FOUND");
		$fatal(1, "completion mismatch");
	endtask

	// staged packets go out on the falling edge
	task automatic send_cycle();
		@(negedge clk);
		for (int l = 0; l < NUM_LANES; l++) begin
			if (nxt[l].valid) begin
				nxt[l].rob_idx = rob_ctr;
				rob_ctr = rob_ctr + 1'b1;
			end
			issue[l] = nxt[l];
			nxt[l] = '0;
		end
	endtask

	task automatic drain();
		repeat (DRAIN_CYCLES) send_cycle();
	endtask

	task automatic idle_after_reset();
		repeat (4) send_cycle();
		// sweep all 64 registers as sources
		for (int c = 0; c < 8; c++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				nxt[l] = build_pkt(PREG_W'(8*c + 2*l), PREG_W'(8*c + 2*l + 1), PREG_W'(c),
					1'b0, 16'h0, 1'b0, MODE_OR, 1'b0, 1'b0);
			end
			send_cycle();
		end
		drain();
	endtask

	task automatic modes_on_all_lanes();
		for (int c = 0; c < 2; c++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				nxt[l] = build_pkt(6'd0, 6'd0, PREG_W'(8 + 2*l + c), 1'b1, rand_bits(16),
					1'b1, MODE_ADD, 1'b0, 1'b1);
			end
			send_cycle();
		end
		repeat (2) send_cycle();
		for (int m = 0; m < 8; m++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				nxt[l] = build_pkt(PREG_W'(8 + 2*l), PREG_W'(9 + 2*l), PREG_W'(16 + l),
					1'b0, 16'h0, 1'b0, MODE_W'(m), 1'b0, 1'b1);
			end
			send_cycle();
		end
		drain();
	endtask

	task automatic operand_options();
		logic [2:0] f;
		for (int c = 0; c < 8; c++) begin
			f = 3'(c);
			for (int l = 0; l < NUM_LANES; l++) begin
				nxt[l] = build_pkt(PREG_W'(8 + 2*l), PREG_W'(9 + 2*l), PREG_W'(20 + l),
					f[0], rand_bits(16), f[1], MODE_W'(rand_bits(3)), f[2], 1'b1);
			end
			send_cycle();
		end
		drain();
	endtask

	task automatic random_traffic();
		for (int c = 0; c < RANDOM_LEN; c++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				nxt[l] = build_pkt(PREG_W'(rand_bits(6)), PREG_W'(rand_bits(6)),
					PREG_W'(rand_bits(6)), rand_bits(1) != 0, rand_bits(16),
					rand_bits(2) == 0, MODE_W'(rand_bits(3)), rand_bits(1) != 0,
					rand_bits(3) != 0);
			end
			send_cycle();
		end
		drain();
	endtask

	task automatic dependent_reads();
		nxt[0] = build_pkt(6'd0, 6'd0, 6'd40, 1'b1, 16'h1234, 1'b1, MODE_ADD, 1'b0, 1'b1);
		send_cycle();
		repeat (3) send_cycle();
		// producer followed by an early and an on-time consumer
		nxt[0] = build_pkt(6'd0, 6'd0, 6'd40, 1'b1, 16'hbeef, 1'b1, MODE_ADD, 1'b0, 1'b1);
		send_cycle();
		send_cycle();
		nxt[1] = build_pkt(6'd40, 6'd0, 6'd41, 1'b1, 16'h0, 1'b0, MODE_ADD, 1'b0, 1'b1);
		send_cycle();
		nxt[2] = build_pkt(6'd40, 6'd0, 6'd42, 1'b1, 16'h0, 1'b0, MODE_ADD, 1'b0, 1'b1);
		send_cycle();
		drain();
	endtask

	task automatic same_dst_conflict();
		nxt[1] = build_pkt(6'd0, 6'd0, 6'd50, 1'b1, 16'h1111, 1'b1, MODE_ADD, 1'b0, 1'b1);
		nxt[2] = build_pkt(6'd0, 6'd0, 6'd51, 1'b1, 16'h2222, 1'b1, MODE_ADD, 1'b0, 1'b0);
		nxt[3] = build_pkt(6'd0, 6'd0, 6'd50, 1'b1, 16'h3333, 1'b1, MODE_ADD, 1'b0, 1'b1);
		send_cycle();
		repeat (3) send_cycle();
		nxt[0] = build_pkt(6'd50, 6'd0, 6'd52, 1'b1, 16'h0, 1'b0, MODE_ADD, 1'b0, 1'b0);
		nxt[1] = build_pkt(6'd51, 6'd0, 6'd53, 1'b1, 16'h0, 1'b0, MODE_ADD, 1'b0, 1'b0);
		send_cycle();
		drain();
	endtask

	// shadow writes land before the new packets read it
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NUM_PREGS; r++) begin
				shadow[r] = '0;
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				exp_cmp[l] = '0;
				for (int d = 0; d < 3; d++) begin
					hist[d][l] = '0;
				end
			end
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				exp_cmp[l] = hist[2][l];
				// ascending order lets the higher lane win
				if (hist[2][l].valid && hist[2][l].reg_wrt) begin
					shadow[hist[2][l].dst] = hist[2][l].data;
				end
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				hist[2][l] = hist[1][l];
				hist[1][l] = hist[0][l];
				hist[0][l].valid   = issue[l].valid;
				hist[0][l].rob_idx = issue[l].rob_idx;
				hist[0][l].dst     = issue[l].dst;
				hist[0][l].reg_wrt = issue[l].reg_wrt;
				hist[0][l].data    = calc_result(issue[l].mode, issue[l].inv_rt, issue[l].ldi,
					shadow[issue[l].src1], issue[l].imm_vld ? issue[l].imm : shadow[issue[l].src2]);
			end
		end
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_cmp
		a_valid: assert property (@(negedge clk) disable iff (!rst_n)
			completion[l].valid == exp_cmp[l].valid)
			else report_value("valid", l, exp_cmp[l].valid, completion[l].valid);
		a_rob: assert property (@(negedge clk) disable iff (!rst_n)
			exp_cmp[l].valid |-> completion[l].rob_idx == exp_cmp[l].rob_idx)
			else report_value("rob_idx", l, exp_cmp[l].rob_idx, completion[l].rob_idx);
		a_dst: assert property (@(negedge clk) disable iff (!rst_n)
			exp_cmp[l].valid |-> completion[l].dst == exp_cmp[l].dst)
			else report_value("dst", l, exp_cmp[l].dst, completion[l].dst);
		a_wrt: assert property (@(negedge clk) disable iff (!rst_n)
			exp_cmp[l].valid |-> completion[l].reg_wrt == exp_cmp[l].reg_wrt)
			else report_value("reg_wrt", l, exp_cmp[l].reg_wrt, completion[l].reg_wrt);
		a_data: assert property (@(negedge clk) disable iff (!rst_n)
			exp_cmp[l].valid |-> completion[l].data == exp_cmp[l].data)
			else report_value("data", l, exp_cmp[l].data, completion[l].data);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		lfsr = 32'h5546;
		rob_ctr = '0;
		cycles = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			issue[l] = '0;
			nxt[l] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		idle_after_reset();
		modes_on_all_lanes();
		operand_options();
		random_traffic();
		dependent_reads();
		same_dst_conflict();
		// let the last completion be checked
		repeat (2) @(negedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: looper_backend.f
design/looper_pkg.sv
design/phys_reg_file.sv
design/operand_fetch.sv
design/exec_lane.sv
design/writeback_collect.sv
design/looper_backend.sv
verif/looper_backend_tb.sv

// File: Bender.yml
package:
  name: looper_backend

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - files:
      - design/looper_pkg.sv
      - design/phys_reg_file.sv
      - design/operand_fetch.sv
      - design/exec_lane.sv
      - design/writeback_collect.sv
      - design/looper_backend.sv

  # testbench, top module looper_backend_tb
  - target: test
    files:
      - verif/looper_backend_tb.sv

# simulation sources are also listed in looper_backend.f
# in the same compile order
